//--- design/pwm_pkg.sv
/*
  Shared widths, register map and FSM encodings for the PWM subsystem.
  Register addresses are word addresses; each channel owns NUM_REGS words.
*/
package pwm_pkg;

   // bus widths
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   // words per channel, also the address stride between channels
   localparam int NUM_REGS = 4;

   // register offset inside a channel
   typedef enum logic [1:0] {
      REG_PERIOD  = 2'd0,
      REG_ON_TIME = 2'd1,
      REG_CONFIG  = 2'd2,
      REG_STATUS  = 2'd3
   } pwm_reg_e;

   // four-phase responder
   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_ACCESS,
      BUS_ACK
   } bus_state_e;

   // pulse sequencer
   typedef enum logic [1:0] {
      PULSE_IDLE,
      PULSE_ON,
      PULSE_OFF
   } pulse_state_e;

endpackage

//--- design/io_bus_if.sv
/*
  Four-phase register bus. The host holds handshake_1 and the request
  fields stable until handshake_2 rises; rd_data is only valid while
  handshake_2 is high.
*/
`timescale 1ns/1ns

interface io_bus_if;
   import pwm_pkg::*;

   logic              handshake_1;
   logic              handshake_2;
   logic              rw;
   logic [ADDR_W-1:0] reg_address;
   logic [DATA_W-1:0] wr_data;
   logic [DATA_W-1:0] rd_data;

   modport host (
      output handshake_1, rw, reg_address, wr_data,
      input  handshake_2, rd_data
   );

   modport slave (
      input  handshake_1, rw, reg_address, wr_data,
      output handshake_2, rd_data
   );

endinterface

//--- design/bus_fsm.sv
/*
  Four-phase responder for one channel. A request is taken only when
  selected is high in BUS_IDLE. handshake_2 rises two clocks after the
  request is first sampled and drops on the edge that sees handshake_1 low.
*/
`timescale 1ns/1ns

module bus_fsm (
   input  logic clk,
   input  logic reset,
   input  logic selected,
   input  logic handshake_1,
   input  logic rw,
   output logic handshake_2,
   output logic write_strobe,
   output logic read_strobe
);
   import pwm_pkg::*;

   bus_state_e state, state_next;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state       <= BUS_IDLE;
         handshake_2 <= 1'b0;
      end else begin
         state       <= state_next;
         // ack lags entry to BUS_ACK by one clock, falls with the request
         handshake_2 <= (state == BUS_ACK) && handshake_1;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         BUS_IDLE:   if (handshake_1 && selected) state_next = BUS_ACCESS;
         BUS_ACCESS: state_next = BUS_ACK;
         BUS_ACK:    if (!handshake_1) state_next = BUS_IDLE;
         default:    state_next = BUS_IDLE;
      endcase
   end

   // single cycle strobes during the access state
   assign write_strobe = (state == BUS_ACCESS) && rw;
   assign read_strobe  = (state == BUS_ACCESS) && !rw;

   // ack only ever follows a completed access cycle
   ack_after_access: assert property (
      @(posedge clk) disable iff (!reset)
      $rose(handshake_2) |-> $past(state, 2) == BUS_ACCESS
   );

endmodule

//--- design/pulse_fsm.sv
/*
  Pulse sequencer. All decisions are taken on tick; the datapath loads the
  on count already clipped to the period and the period count minus one,
  so period_zero marks the last tick of a period.
*/
`timescale 1ns/1ns

module pulse_fsm (
   input  logic clk,
   input  logic reset,
   input  logic enable,
   input  logic tick,
   input  logic on_zero,
   input  logic period_zero,
   output logic dec_on,
   output logic dec_period,
   output logic reload,
   output logic pwm
);
   import pwm_pkg::*;

   pulse_state_e state, state_next;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= PULSE_IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = state;
      reload     = 1'b0;
      case (state)
         PULSE_IDLE: begin
            if (tick && enable) begin
               reload     = 1'b1;
               state_next = PULSE_ON;
            end
         end
         PULSE_ON, PULSE_OFF: begin
            if (tick) begin
               if (period_zero) begin
                  // enable is only looked at on a period boundary
                  reload     = 1'b1;
                  state_next = enable ? PULSE_ON : PULSE_IDLE;
               end else if (state == PULSE_ON && on_zero) begin
                  state_next = PULSE_OFF;
               end
            end
         end
         default: state_next = PULSE_IDLE;
      endcase
   end

   assign dec_on     = tick && (state == PULSE_ON) && !on_zero;
   assign dec_period = tick && (state != PULSE_IDLE) && !period_zero;
   assign pwm        = (state == PULSE_ON) && !on_zero;

   // off phase only once the on count has run out
   off_after_on_done: assert property (
      @(posedge clk) disable iff (!reset)
      (state == PULSE_OFF) |-> on_zero
   );

endmodule

//--- design/pwm_channel.sv
/*
  One PWM channel at word addresses CHANNEL_ID*NUM_REGS and up.
  Period and on time count ticks of TICK_CYCLES clocks. New values and
  enable changes take effect at the next period boundary. Status mirrors
  config and ignores writes. rd_data is zero unless this channel acks.
*/
`timescale 1ns/1ns

module pwm_channel #(
   parameter int CHANNEL_ID  = 0,
   parameter int TICK_CYCLES = 2
) (
   input  logic     clk,
   input  logic     reset,
   io_bus_if.slave  bus,
   output logic     pwm_signal
);
   import pwm_pkg::*;

   localparam int REG_AW = $clog2(NUM_REGS);
   localparam int SEL_W  = ADDR_W - REG_AW;
   localparam int PRE_W  = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

   logic [DATA_W-1:0] period_reg, on_time_reg, config_reg;
   logic [DATA_W-1:0] period_cnt, on_cnt, period_load, on_load;
   logic [DATA_W-1:0] read_word, rd_q;
   logic [PRE_W-1:0]  pre_cnt;
   pwm_reg_e          reg_offset;
   logic selected, ack, write_strobe, read_strobe;
   logic tick, on_zero, period_zero, dec_on, dec_period, reload;

   assign selected   = bus.reg_address[ADDR_W-1:REG_AW] == SEL_W'(CHANNEL_ID);
   assign reg_offset = pwm_reg_e'(bus.reg_address[REG_AW-1:0]);

   bus_fsm bus_fsm_i (
      .clk          (clk),
      .reset        (reset),
      .selected     (selected),
      .handshake_1  (bus.handshake_1),
      .rw           (bus.rw),
      .handshake_2  (ack),
      .write_strobe (write_strobe),
      .read_strobe  (read_strobe)
   );

   pulse_fsm pulse_fsm_i (
      .clk         (clk),
      .reset       (reset),
      .enable      (config_reg[0]),
      .tick        (tick),
      .on_zero     (on_zero),
      .period_zero (period_zero),
      .dec_on      (dec_on),
      .dec_period  (dec_period),
      .reload      (reload),
      .pwm         (pwm_signal)
   );

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_reg  <= '0;
         on_time_reg <= '0;
         config_reg  <= '0;
      end else if (write_strobe) begin
         case (reg_offset)
            REG_PERIOD:  period_reg  <= bus.wr_data;
            REG_ON_TIME: on_time_reg <= bus.wr_data;
            REG_CONFIG:  config_reg  <= bus.wr_data;
            default:     ;
         endcase
      end
   end

   always_comb begin
      case (reg_offset)
         REG_PERIOD:  read_word = period_reg;
         REG_ON_TIME: read_word = on_time_reg;
         default:     read_word = config_reg;
      endcase
   end

   // captured during the access cycle, cleared by writes
   always_ff @(posedge clk) begin
      if (read_strobe) begin
         rd_q <= read_word;
      end else if (write_strobe) begin
         rd_q <= '0;
      end
   end

   assign bus.handshake_2 = ack;
   assign bus.rd_data     = ack ? rd_q : '0;

   // free running prescaler
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pre_cnt <= '0;
      end else if (tick) begin
         pre_cnt <= '0;
      end else begin
         pre_cnt <= pre_cnt + 1'b1;
      end
   end

   assign tick = (pre_cnt == PRE_W'(TICK_CYCLES - 1));

   // on time clipped to the period, period minus one so zero marks the last tick
   assign on_load     = (on_time_reg < period_reg) ? on_time_reg : period_reg;
   assign period_load = (period_reg == '0) ? '0 : period_reg - DATA_W'(1);

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         on_cnt     <= '0;
         period_cnt <= '0;
      end else begin
         if (reload) begin
            on_cnt <= on_load;
         end else if (dec_on) begin
            on_cnt <= on_cnt - DATA_W'(1);
         end
         if (reload) begin
            period_cnt <= period_load;
         end else if (dec_period) begin
            period_cnt <= period_cnt - DATA_W'(1);
         end
      end
   end

   assign on_zero     = (on_cnt == '0);
   assign period_zero = (period_cnt == '0);

   // strobes only while the address still points at this channel
   strobe_selected: assert property (
      @(posedge clk) disable iff (!reset)
      (write_strobe || read_strobe) |-> selected
   );

endmodule

//--- design/pwm_subsystem.sv
/*
  PWM subsystem with NUM_CHANNELS channels on one register bus.
  Channel n occupies word addresses n*NUM_REGS to n*NUM_REGS+3; anything
  above is never acknowledged. Acks and read words of all channels are ORed.
*/
`timescale 1ns/1ns

module pwm_subsystem #(
   parameter int NUM_CHANNELS = 3,
   parameter int TICK_CYCLES  = 2
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        handshake_1,
   input  logic                        rw,
   input  logic [pwm_pkg::ADDR_W-1:0]  reg_address,
   input  logic [pwm_pkg::DATA_W-1:0]  wr_data,
   output logic                        handshake_2,
   output logic [pwm_pkg::DATA_W-1:0]  rd_data,
   output logic [NUM_CHANNELS-1:0]     pwm_signal
);
   import pwm_pkg::*;

   logic [NUM_CHANNELS-1:0] ack_vec;
   logic [DATA_W-1:0]       rd_vec [NUM_CHANNELS];

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
      io_bus_if bus_i ();

      // request side is broadcast
      assign bus_i.handshake_1 = handshake_1;
      assign bus_i.rw          = rw;
      assign bus_i.reg_address = reg_address;
      assign bus_i.wr_data     = wr_data;

      assign ack_vec[i] = bus_i.handshake_2;
      assign rd_vec[i]  = bus_i.rd_data;

      pwm_channel #(
         .CHANNEL_ID  (i),
         .TICK_CYCLES (TICK_CYCLES)
      ) chan_i (
         .clk        (clk),
         .reset      (reset),
         .bus        (bus_i.slave),
         .pwm_signal (pwm_signal[i])
      );
   end

   assign handshake_2 = |ack_vec;

   // idle channels drive zero, so OR is enough
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         rd_data = rd_data | rd_vec[i];
      end
   end

endmodule

//--- verif/pwm_tb.sv
/*
  Testbench for pwm_subsystem with default parameters, 3 channels and
  2 clocks per tick. Inputs change 1 ns after the rising edge and outputs
  are sampled at the same point, when they are settled.
*/
`timescale 1ns/1ns

module pwm_tb;
   import pwm_pkg::*;

   localparam int NUM_CHANNELS   = 3;
   localparam int TICK_CYCLES    = 2;
   localparam int CLK_HALF       = 4;
   localparam int ACK_WAIT       = 8;
   localparam int NUM_ROUNDTRIPS = 60;
   localparam int MAPPED_WORDS   = NUM_CHANNELS * NUM_REGS;
   // expected run is about 2500 cycles
   localparam int TIMEOUT_CYCLES = 20000;

   logic                    clk;
   logic                    reset;
   logic                    handshake_1;
   logic                    rw;
   logic [ADDR_W-1:0]       reg_address;
   logic [DATA_W-1:0]       wr_data;
   logic                    handshake_2;
   logic [DATA_W-1:0]       rd_data;
   logic [NUM_CHANNELS-1:0] pwm_signal;

   // shadow copy, status words are unused since they mirror config
   logic [DATA_W-1:0] shadow [MAPPED_WORDS];
   int errors;
   int transfers;
   int cycle_count;

   pwm_subsystem dut_i (
      .clk         (clk),
      .reset       (reset),
      .handshake_1 (handshake_1),
      .rw          (rw),
      .reg_address (reg_address),
      .wr_data     (wr_data),
      .handshake_2 (handshake_2),
      .rd_data     (rd_data),
      .pwm_signal  (pwm_signal)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      errors++;
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("transfers: %0d, errors: %0d", transfers, errors);
      $display("Testbench failed");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                  input logic [DATA_W-1:0] exp);
      errors++;
      $display("CHECK FAILED %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, exp);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // one four-phase transfer, called 1 ns after a rising edge
   task automatic run_transfer(input logic is_write, input int addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata);
      int  n;
      int  hold;
      bit  acked;
      bit  mapped;
      mapped = (addr < MAPPED_WORDS);
      rdata = '0;
      acked = 1'b0;
      n = 0;
      transfers++;
      handshake_1 = 1'b1;
      rw = is_write;
      reg_address = ADDR_W'(addr);
      wr_data = wdata;
      while (!acked && n < ACK_WAIT) begin
         next_cycle();
         n++;
         acked = handshake_2;
      end
      if (mapped && !acked) begin
         errors++;
         $display("no acknowledge within %0d cycles for address 0x%0h", ACK_WAIT, addr);
      end else if (!mapped && acked) begin
         errors++;
         $display("unmapped access was acknowledged at address 0x%0h", addr);
      end
      if (mapped && acked) begin
         // edge 1 samples the request, ack is visible after edge 3
         if (n != 3) report_mismatch("handshake_2 delay", n - 1, 2);
         rdata = rd_data;
         hold = $urandom % 3;
         repeat (hold) begin
            next_cycle();
            if (handshake_2 !== 1'b1) report_mismatch("handshake_2", handshake_2, 1);
         end
      end
      handshake_1 = 1'b0;
      next_cycle();
      if (handshake_2 !== 1'b0) report_mismatch("handshake_2", handshake_2, 0);
   endtask

   task automatic bus_write(input int addr, input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] unused;
      run_transfer(1'b1, addr, data, unused);
   endtask

   task automatic bus_read(input int addr, output logic [DATA_W-1:0] data);
      run_transfer(1'b0, addr, '0, data);
   endtask

   function automatic logic [DATA_W-1:0] expected_word(input int addr);
      if (addr % NUM_REGS == int'(REG_STATUS)) return shadow[addr - 1];
      return shadow[addr];
   endfunction

   // status and unmapped words never change the model
   task automatic write_reg(input int addr, input logic [DATA_W-1:0] data);
      bus_write(addr, data);
      if (addr < MAPPED_WORDS && addr % NUM_REGS != int'(REG_STATUS)) shadow[addr] = data;
   endtask

   task automatic read_and_compare(input int addr);
      logic [DATA_W-1:0] got;
      bus_read(addr, got);
      if (got !== expected_word(addr)) begin
         report_mismatch($sformatf("rd_data[0x%0h]", addr), got, expected_word(addr));
      end
   endtask

   task automatic sweep_registers();
      for (int a = 0; a < MAPPED_WORDS; a++) read_and_compare(a);
   endtask

   task automatic wait_rise(input int ch, input int limit, output int cycles, output bit found);
      logic prev;
      prev = pwm_signal[ch];
      cycles = 0;
      found = 1'b0;
      while (!found && cycles < limit) begin
         next_cycle();
         cycles++;
         if (!prev && pwm_signal[ch]) found = 1'b1;
         prev = pwm_signal[ch];
      end
   endtask

   // on_mode 0 forces a zero on time, 1 forces on time at or above the period
   task automatic measure_waveform(input int ch, input int on_mode);
      int period_ticks;
      int on_ticks;
      int period_clks;
      int high_exp;
      int high_cnt;
      int gap;
      int waited;
      bit found;
      int base;
      base = ch * NUM_REGS;
      period_ticks = 4 + $urandom % 17;
      case (on_mode)
         0:       on_ticks = 0;
         1:       on_ticks = period_ticks + $urandom % 3;
         default: on_ticks = $urandom % (period_ticks + 3);
      endcase
      period_clks = period_ticks * TICK_CYCLES;
      high_exp = ((on_ticks < period_ticks) ? on_ticks : period_ticks) * TICK_CYCLES;
      write_reg(base + int'(REG_PERIOD), period_ticks);
      write_reg(base + int'(REG_ON_TIME), on_ticks);
      write_reg(base + int'(REG_CONFIG), 1);
      // first reload within one tick, then two full periods
      repeat (2 * period_clks + TICK_CYCLES) next_cycle();
      // any window one period long holds the whole high phase
      high_cnt = 0;
      repeat (period_clks) begin
         next_cycle();
         if (pwm_signal[ch]) high_cnt++;
      end
      if (high_cnt != high_exp) begin
         report_mismatch($sformatf("pwm_signal[%0d] high clocks", ch), high_cnt, high_exp);
      end
      if (high_exp > 0 && high_exp < period_clks) begin
         wait_rise(ch, period_clks + 1, gap, found);
         if (found) wait_rise(ch, period_clks + 1, gap, found);
         if (!found) begin
            errors++;
            $display("no rising edge on pwm_signal[%0d] within one period", ch);
         end else if (gap != period_clks) begin
            report_mismatch($sformatf("pwm_signal[%0d] period clocks", ch), gap, period_clks);
         end
      end
      write_reg(base + int'(REG_CONFIG), 0);
      waited = 0;
      while (pwm_signal[ch] && waited < period_clks) begin
         next_cycle();
         waited++;
      end
      if (pwm_signal[ch]) begin
         errors++;
         $display("pwm_signal[%0d] still high one period after disable", ch);
      end
      high_cnt = 0;
      repeat (2 * period_clks) begin
         next_cycle();
         if (pwm_signal[ch] !== 1'b0) high_cnt++;
      end
      if (high_cnt != 0) begin
         report_mismatch($sformatf("pwm_signal[%0d] high clocks after disable", ch), high_cnt, 0);
      end
   endtask

   initial begin
      int                reg_sel;
      int                addr;
      logic [DATA_W-1:0] data;
      errors = 0;
      transfers = 0;
      void'($urandom(22143));
      reset = 1'b0;
      handshake_1 = 1'b0;
      rw = 1'b0;
      reg_address = '0;
      wr_data = '0;
      foreach (shadow[i]) shadow[i] = '0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b1;

      if (pwm_signal !== '0) report_mismatch("pwm_signal", pwm_signal, 0);
      sweep_registers();

      // enable stays clear so every channel idles during register traffic
      repeat (NUM_ROUNDTRIPS) begin
         reg_sel = $urandom % 3;
         addr = ($urandom % NUM_CHANNELS) * NUM_REGS + reg_sel;
         data = $urandom;
         if (reg_sel == int'(REG_CONFIG)) data[0] = 1'b0;
         write_reg(addr, data);
         repeat (2) read_and_compare($urandom % MAPPED_WORDS);
      end

      bus_read(MAPPED_WORDS + $urandom % ((1 << ADDR_W) - MAPPED_WORDS), data);
      write_reg(MAPPED_WORDS + $urandom % ((1 << ADDR_W) - MAPPED_WORDS), $urandom);
      sweep_registers();

      // runs 3 and 4 pin down constant low and constant high
      for (int k = 0; k < 6; k++) begin
         measure_waveform(k % NUM_CHANNELS, (k == 3) ? 0 : (k == 4) ? 1 : 2);
      end
      sweep_registers();

      $display("transfers: %0d, errors: %0d", transfers, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- pwm_subsystem.f
design/pwm_pkg.sv
design/io_bus_if.sv
design/bus_fsm.sv
design/pulse_fsm.sv
design/pwm_channel.sv
design/pwm_subsystem.sv
verif/pwm_tb.sv

//--- Bender.yml
package:
  name: pwm_subsystem

sources:
  - files:
      - design/pwm_pkg.sv
      - design/io_bus_if.sv
      - design/bus_fsm.sv
      - design/pulse_fsm.sv
      - design/pwm_channel.sv
      - design/pwm_subsystem.sv
  - target: simulation
    files:
      - verif/pwm_tb.sv
